/* common/logo_defines.svh */
// build-time defines for colour width, logo size, memory width and chip id strip position
`ifndef LOGO_DEFINES_SVH
`define LOGO_DEFINES_SVH

// video colour depth, bits per channel
`define LOGO_COLOR_W 4

// logo bitmap in screen pixels
`define LOGO_W 256
`define LOGO_H 128

// bitmap store is 2**11 bytes
// 8 bit rows of 256 pixels, each row drawn over 16 lines
`define LOGO_PROM_AW 11

// top left corner of the chip id strip, in active pixels and lines
`define HEX_H0 64
`define HEX_V0 192

// one hex digit per nibble of the 64-bit id
`define HEX_DIGITS 16

`endif

/* common/logo_pkg.sv */
// logo overlay types for coordinates, memory address and data, and the 8x8 hex font table
`include "logo_defines.svh"

package logo_pkg;

    typedef logic [8:0] coord_t;                        // screen x or y, up to 511
    typedef logic [`LOGO_PROM_AW-1:0] prom_addr_t;      // bitmap byte address
    typedef logic [7:0] prom_byte_t;                    // one byte of bitmap

    // glyphs 0..f, row 0 on top, bit 7 is the leftmost pixel
    // last row left blank as spacing to the next line of text
    localparam logic [7:0] hex_font [16][8] = '{
        '{8'h3c, 8'h66, 8'h6e, 8'h76, 8'h66, 8'h66, 8'h3c, 8'h00},   // 0
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7e, 8'h00},   // 1
        '{8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e, 8'h00},   // 2
        '{8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c, 8'h00},   // 3
        '{8'h0c, 8'h1c, 8'h3c, 8'h6c, 8'h7e, 8'h0c, 8'h0c, 8'h00},   // 4
        '{8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c, 8'h00},   // 5
        '{8'h3c, 8'h66, 8'h60, 8'h7c, 8'h66, 8'h66, 8'h3c, 8'h00},   // 6
        '{8'h7e, 8'h66, 8'h0c, 8'h18, 8'h18, 8'h18, 8'h18, 8'h00},   // 7
        '{8'h3c, 8'h66, 8'h66, 8'h3c, 8'h66, 8'h66, 8'h3c, 8'h00},   // 8
        '{8'h3c, 8'h66, 8'h66, 8'h3e, 8'h06, 8'h66, 8'h3c, 8'h00},   // 9
        '{8'h18, 8'h3c, 8'h66, 8'h7e, 8'h66, 8'h66, 8'h66, 8'h00},   // a
        '{8'h7c, 8'h66, 8'h66, 8'h7c, 8'h66, 8'h66, 8'h7c, 8'h00},   // b
        '{8'h3c, 8'h66, 8'h60, 8'h60, 8'h60, 8'h66, 8'h3c, 8'h00},   // c
        '{8'h78, 8'h6c, 8'h66, 8'h66, 8'h66, 8'h6c, 8'h78, 8'h00},   // d
        '{8'h7e, 8'h60, 8'h60, 8'h78, 8'h60, 8'h60, 8'h7e, 8'h00},   // e
        '{8'h7e, 8'h60, 8'h60, 8'h78, 8'h60, 8'h60, 8'h60, 8'h00}    // f
    };

endpackage

/* hexdisplay/hex_display.sv */
// hex_display, renders the 64-bit chip id as a strip of hex glyphs at a fixed position
`timescale 1ns/1ps
`include "logo_defines.svh"

module hex_display (
    input  logo_pkg::coord_t hcnt,
    input  logo_pkg::coord_t vcnt,
    input  logic [63:0]      chipid,    // digit 0 is the top nibble
    output logic             pxl        // 1 where a glyph pixel is lit
);

    localparam int unsigned CELL    = 8;                    // glyph cell, 8x8
    localparam int unsigned STRIP_W = `HEX_DIGITS * CELL;   // 128 pixels wide

    logo_pkg::coord_t hoff;         // position inside the strip
    logo_pkg::coord_t voff;
    logic             in_strip;
    logic [3:0]       digit;        // which of the 16 cells
    logic [63:0]      id_shift;     // selected nibble moved to the top
    logic [3:0]       nibble;
    logic [2:0]       row;          // glyph row
    logic [2:0]       col;          // glyph column, 0 on the left
    logic [7:0]       glyph_row;

    always_comb begin
        hoff = hcnt - 9'(`HEX_H0);
        voff = vcnt - 9'(`HEX_V0);

        // strip window, one glyph row high
        in_strip = (hcnt >= 9'(`HEX_H0)) && (hcnt < 9'(`HEX_H0 + STRIP_W)) &&
                   (vcnt >= 9'(`HEX_V0)) && (vcnt < 9'(`HEX_V0 + CELL));

        digit = hoff[6:3];          // 8 pixels per digit
        col   = hoff[2:0];
        row   = voff[2:0];

        // most significant nibble drawn first
        id_shift = chipid << {digit, 2'b00};
        nibble   = id_shift[63:60];

        glyph_row = logo_pkg::hex_font[nibble][row];
        pxl       = in_strip & glyph_row[3'd7 - col];   // bit 7 is leftmost
    end

endmodule

/* logo/logo_mixer.sv */
// logo_mixer, logo position and zone test, memory address, and overlay or pass-through output
`timescale 1ns/1ps
`include "logo_defines.svh"

module logo_mixer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pxl_cen,
    input  logic                           show_en,   // 0 passes core video
    input  logo_pkg::coord_t               hcnt,
    input  logo_pkg::coord_t               vcnt,
    input  logo_pkg::coord_t               hover,
    input  logo_pkg::coord_t               vover,
    input  logo_pkg::prom_byte_t           rom,       // bitmap byte for addr
    input  logic                           idpxl,     // chip id pixel
    input  logic [3*`LOGO_COLOR_W-1:0]     rgb_in,
    input  logic                           hs,
    input  logic                           vs,
    input  logic                           lhbl,
    input  logic                           lvbl,
    output logo_pkg::prom_addr_t           addr,
    output logic [3*`LOGO_COLOR_W-1:0]     rgb_out,
    output logic                           hs_out,
    output logic                           vs_out,
    output logic                           lhbl_out,
    output logic                           lvbl_out
);

    logic [9:0]                hdiff;   // signed position in logo, bit 9 is sign
    logic [9:0]                vdiff;
    logic                      inzone;
    logic                      ovl_pxl; // logo bit or chip id bit
    logic [`LOGO_COLOR_W-1:0]  r_in;
    logic [`LOGO_COLOR_W-1:0]  g_in;
    logic [`LOGO_COLOR_W-1:0]  b_in;
    logic [`LOGO_COLOR_W-1:0]  r_out;
    logic [`LOGO_COLOR_W-1:0]  g_out;
    logic [`LOGO_COLOR_W-1:0]  b_out;

    // one overlay decision for every channel
    function automatic logic [`LOGO_COLOR_W-1:0] filter(
        input logic [`LOGO_COLOR_W-1:0] v,
        input logic                     en,
        input logic                     bit_on
    );
        filter = en ? {`LOGO_COLOR_W{bit_on}} : v;
    endfunction

    assign {r_in, g_in, b_in} = rgb_in;
    assign rgb_out = {r_out, g_out, b_out};

    always_comb begin
        hdiff  = {1'b0, hcnt} - {1'b0, hover};
        vdiff  = {1'b0, vcnt} - {1'b0, vover};
        inzone = !hdiff[9] && (hdiff < 10'(`LOGO_W)) &&
                 !vdiff[9] && (vdiff < 10'(`LOGO_H));
    end

    // 8 bit rows of 256 columns, a byte holds one column of 8 bit rows
    assign addr    = {vdiff[6:4], hdiff[7:0]};
    assign ovl_pxl = inzone ? rom[vdiff[3:1]] : idpxl;     // each bit row on two lines

    // output stage, one pixel of delay for syncs and colour alike
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_out   <= 1'b0;
            vs_out   <= 1'b0;
            lhbl_out <= 1'b0;
            lvbl_out <= 1'b0;
            r_out    <= '0;
            g_out    <= '0;
            b_out    <= '0;
        end else if (pxl_cen) begin
            hs_out   <= hs;
            vs_out   <= vs;
            lhbl_out <= lhbl;
            lvbl_out <= lvbl;
            r_out    <= filter(r_in, show_en, ovl_pxl);
            g_out    <= filter(g_in, show_en, ovl_pxl);
            b_out    <= filter(b_in, show_en, ovl_pxl);
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the logo overlay testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --top-module tb_logo_overlay -f sim.f -o tb_logo_overlay \
    > build.log 2>&1 \
    && ./obj_dir/tb_logo_overlay > sim.log 2>&1 \
    || echo "test failed" >> sim.log

cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation FAILED, see sim.log and build.log"
    exit 1
fi
echo "simulation PASSED"
exit 0

/* sim.f */
+incdir+common
common/logo_pkg.sv
verilog/logo_prom.sv
verilog/screen_measure.sv
hexdisplay/hex_display.sv
logo/logo_mixer.sv
verilog/logo_overlay_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_logo_overlay.sv

/* test/tb_checker.sv */
// testbench checker, model of counters and pixel rule, per-pixel compare and error count
`timescale 1ns/1ps
`include "logo_defines.svh"

module tb_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    input  logic                       show_en,
    input  logic [3*`LOGO_COLOR_W-1:0] rgb_in,
    input  logic                       hs,
    input  logic                       vs,
    input  logic                       lhbl,
    input  logic                       lvbl,
    input  logic [63:0]                chipid,
    input  logo_pkg::prom_byte_t       bitmap [2**`LOGO_PROM_AW],  // copy of the memory
    input  logic [3*`LOGO_COLOR_W-1:0] rgb_out,
    input  logic                       hs_out,
    input  logic                       vs_out,
    input  logic                       lhbl_out,
    input  logic                       lvbl_out,
    output int                         value_errs,
    output int                         lit_pixels   // overlay pixels seen lit on rgb_out
);

    localparam int RGB_W = 3 * `LOGO_COLOR_W;

    int               m_hcnt;       // model counters, as before the current edge
    int               m_vcnt;
    int               m_htot;
    int               m_vtot;
    int               m_hover;
    int               m_vover;
    logic             m_lhbl;       // blanking one pixel ago
    logic             m_lvbl;
    logic             seen_cen;
    logic [RGB_W-1:0] exp_rgb;
    logic [3:0]       exp_sync;
    string            tname;

    // expected colour for one pixel from the counters seen before the edge
    function automatic logic [RGB_W-1:0] expected_rgb(
        input logic             show,
        input logic [RGB_W-1:0] rgb,
        input int               hc,
        input int               vc,
        input int               ho,
        input int               vo
    );
        int                   h;
        int                   v;
        int                   hx;
        logo_pkg::prom_addr_t a;
        logic [2:0]           bsel;
        logic [2:0]           row;
        logic [2:0]           col;
        logic [3:0]           nib;
        logic [7:0]           glyph;
        logic                 lit;
        h   = hc - ho;
        v   = vc - vo;
        hx  = hc - `HEX_H0;
        lit = 1'b0;
        if (h >= 0 && h < `LOGO_W && v >= 0 && v < `LOGO_H) begin
            a    = logo_pkg::prom_addr_t'((v / 16) * 256 + h);  // 16 lines per byte row
            bsel = 3'((v % 16) / 2);                            // bit row drawn twice
            lit  = bitmap[a][bsel];
        end else if (hx >= 0 && hx < 8 * `HEX_DIGITS &&
                     vc >= `HEX_V0 && vc < `HEX_V0 + 8) begin
            nib   = 4'(chipid >> (60 - 4 * (hx / 8)));          // digit 0 is the top nibble
            row   = 3'(vc - `HEX_V0);
            col   = 3'(hx % 8);
            glyph = logo_pkg::hex_font[nib][row];
            lit   = glyph[3'd7 - col];
        end
        if (show) begin
            expected_rgb = {RGB_W{lit}};
        end else begin
            expected_rgb = rgb;
        end
    endfunction

    // counter and offset rules, next state from the old values
    task automatic step_model();
        logic hfall;
        logic vfall;
        hfall = m_lhbl && !lhbl;
        vfall = m_lvbl && !lvbl;
        if (vfall) begin
            m_hover = (m_htot < `LOGO_W) ? 0 : (m_htot - `LOGO_W) / 2;
            m_vover = (m_vtot < `LOGO_H) ? 0 : (m_vtot - `LOGO_H) / 2;  // height of frame before
            m_vtot  = m_vcnt;
        end
        if (hfall) begin
            m_htot = m_hcnt;
        end
        if (!lvbl) begin
            m_vcnt = 0;
        end else if (hfall) begin
            m_vcnt = m_vcnt + 1;
        end
        m_hcnt = lhbl ? m_hcnt + 1 : 0;
        m_lhbl = lhbl;
        m_lvbl = lvbl;
    endtask

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // predict at the edge, compare once the outputs have settled
    always @(posedge clk) begin
        if (!rst_n) begin
            m_hcnt     = 0;
            m_vcnt     = 0;
            m_htot     = 0;
            m_vtot     = 0;
            m_hover    = 0;
            m_vover    = 0;
            m_lhbl     = 1'b0;
            m_lvbl     = 1'b0;
            seen_cen   = 1'b0;
            value_errs = 0;
            lit_pixels = 0;
        end else if (pxl_cen) begin
            seen_cen = 1'b1;
            if (show_en) begin
                tname = "overlay";
            end else begin
                tname = "passthrough";
            end
            exp_rgb  = expected_rgb(show_en, rgb_in, m_hcnt, m_vcnt, m_hover, m_vover);
            exp_sync = {hs, vs, lhbl, lvbl};    // syncs are one pixel late
            step_model();
            #1;
            check_value({tname, " rgb_out"}, 16'(exp_rgb), 16'(rgb_out));
            check_value({tname, " syncs"}, 16'(exp_sync),
                        16'({hs_out, vs_out, lhbl_out, lvbl_out}));
            if (show_en && rgb_out[0]) begin
                lit_pixels++;                   // dut really drew something
            end
        end else if (!seen_cen) begin
            #1;                                 // out of reset, no pixel yet
            check_value("reset rgb_out", 16'h0000, 16'(rgb_out));
            check_value("reset syncs", 16'h0000, 16'({hs_out, vs_out, lhbl_out, lvbl_out}));
        end
    end

endmodule

/* test/tb_clock.sv */
// testbench clock source, free running, 20 ns period
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;  // half period high, half low
        end
    end

endmodule

/* test/tb_logo_overlay.sv */
// testbench top, video timing, bitmap download, chip id, show_en sequence and final report
`timescale 1ns/1ps
`include "logo_defines.svh"

module tb_logo_overlay;

    localparam int          RGB_W       = 3 * `LOGO_COLOR_W;
    localparam int          LINE_PX     = 384;
    localparam int          FRAME_LINES = 262;
    localparam int          ACT_LINES   = 240;
    localparam int          FRAME_WAIT  = 700000;    // clk, a bit over three frames
    localparam int          LINE_WAIT   = 250000;
    localparam logic [63:0] CHIP_ID     = 64'h0123_4567_89ab_cdef;

    logic                 clk;
    logic                 rst_n;
    logic                 pxl_cen;
    logic                 show_en;
    logic [RGB_W-1:0]     rgb_in;
    logic                 hs;
    logic                 vs;
    logic                 lhbl;
    logic                 lvbl;
    logo_pkg::prom_addr_t prog_addr;
    logo_pkg::prom_byte_t prog_data;
    logic                 prog_we;
    logic [63:0]          chipid;
    logic [RGB_W-1:0]     rgb_out;
    logic                 hs_out;
    logic                 vs_out;
    logic                 lhbl_out;
    logic                 lvbl_out;

    logo_pkg::prom_byte_t bitmap [2**`LOGO_PROM_AW];  // what the memory should hold
    integer               seed = 32'hfa6d0ea2;
    int                   act_w;                      // active pixels per line
    int                   frame_no;                   // frames started
    int                   line_no;
    logic                 video_on;
    logic                 timed_out;
    int                   other_errs;
    int                   value_errs;
    int                   lit_pixels;

    tb_clock u_clk (.clk(clk));

    logo_overlay_top uut (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .show_en(show_en),
        .rgb_in(rgb_in), .hs(hs), .vs(vs), .lhbl(lhbl), .lvbl(lvbl),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_we(prog_we),
        .chipid(chipid), .rgb_out(rgb_out), .hs_out(hs_out), .vs_out(vs_out),
        .lhbl_out(lhbl_out), .lvbl_out(lvbl_out)
    );

    tb_checker u_chk (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .show_en(show_en),
        .rgb_in(rgb_in), .hs(hs), .vs(vs), .lhbl(lhbl), .lvbl(lvbl),
        .chipid(chipid), .bitmap(bitmap), .rgb_out(rgb_out), .hs_out(hs_out),
        .vs_out(vs_out), .lhbl_out(lhbl_out), .lvbl_out(lvbl_out),
        .value_errs(value_errs), .lit_pixels(lit_pixels)
    );

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        other_errs++;
        $display("timeout while waiting for %s", what);
    endtask

    // model offsets against the centring numbers for the current picture size
    task automatic check_offsets(input string name, input int exp_h, input int exp_v);
        if (u_chk.m_hover != exp_h || u_chk.m_vover != exp_v) begin
            other_errs++;
            $display("Fail %s expected %0d,%0d actual %0d,%0d", name, exp_h, exp_v,
                     u_chk.m_hover, u_chk.m_vover);
        end
    endtask

    task automatic wait_frame(input int n);
        int cycles;
        cycles = 0;
        while (!timed_out && frame_no < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > FRAME_WAIT) begin
                note_timeout("the start of a frame");
            end
        end
    endtask

    task automatic wait_line(input int n);
        int cycles;
        cycles = 0;
        while (!timed_out && line_no < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > LINE_WAIT) begin
                note_timeout("a line inside the frame");
            end
        end
    endtask

    // one download byte, strobe lands on a pixel enable edge
    task automatic write_byte(input logo_pkg::prom_addr_t a, input logo_pkg::prom_byte_t d);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!timed_out && pxl_cen) begin
            @(posedge clk);
            cycles++;
            if (cycles > 4) begin
                note_timeout("the pixel enable phase");
            end
        end
        if (!timed_out) begin
            #2;
            prog_addr = a;
            prog_data = d;
            prog_we   = 1'b1;
            @(posedge clk);
            #2;
            prog_we   = 1'b0;
            bitmap[a] = d;          // copy follows after the write edge
        end
    endtask

    // pixel timing, one pixel every second clk
    initial begin : video_gen
        int px;
        int ln;
        px       = 0;
        ln       = 0;
        frame_no = 0;
        line_no  = 0;
        pxl_cen  = 1'b0;
        rgb_in   = '0;
        hs       = 1'b0;
        vs       = 1'b0;
        lhbl     = 1'b0;
        lvbl     = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (video_on) begin
                if (pxl_cen) begin
                    pxl_cen = 1'b0;
                end else begin
                    if (px == 0 && ln == 0) begin
                        frame_no++;
                    end
                    line_no = ln;
                    pxl_cen = 1'b1;
                    lhbl    = (px < act_w);
                    lvbl    = (ln < ACT_LINES);
                    hs      = (px >= 336 && px < 352);    // inside hblank
                    vs      = (ln >= 244 && ln < 247);
                    rgb_in  = RGB_W'($random(seed));
                    px++;
                    if (px == LINE_PX) begin
                        px = 0;
                        ln = (ln == FRAME_LINES - 1) ? 0 : ln + 1;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        int i;
        rst_n      = 1'b0;
        show_en    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        prog_we    = 1'b0;
        chipid     = CHIP_ID;
        act_w      = 320;
        video_on   = 1'b0;
        timed_out  = 1'b0;
        other_errs = 0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);             // checker sees reset values here
        video_on = 1'b1;
        for (i = 0; i < 2**`LOGO_PROM_AW; i++) begin
            write_byte(logo_pkg::prom_addr_t'(i), logo_pkg::prom_byte_t'($random(seed)));
        end
        wait_frame(3);              // offsets valid from here
        check_offsets("offsets 320x240", 32, 56);
        #2;
        show_en = 1'b1;
        wait_frame(4);
        wait_line(100);             // rewrite while the logo is on screen
        for (i = 0; i < 64; i++) begin
            write_byte(logo_pkg::prom_addr_t'($random(seed)), logo_pkg::prom_byte_t'($random(seed)));
        end
        wait_frame(6);
        #4;
        act_w = 272;                // hover 8 two frames on
        wait_frame(9);
        check_offsets("offsets 272x240", 8, 56);
        if (lit_pixels == 0) begin
            other_errs++;
            $display("no overlay pixel was lit on rgb_out while show_en was high");
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog/logo_overlay_top.sv */
// logo_overlay_top, connects screen counters, bitmap memory, chip id display and mixer
`timescale 1ns/1ps
`include "logo_defines.svh"

module logo_overlay_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic                        show_en,
    input  logic [3*`LOGO_COLOR_W-1:0]  rgb_in,     // from the core
    input  logic                        hs,
    input  logic                        vs,
    input  logic                        lhbl,
    input  logic                        lvbl,
    input  logo_pkg::prom_addr_t        prog_addr,  // bitmap download
    input  logo_pkg::prom_byte_t        prog_data,
    input  logic                        prog_we,
    input  logic [63:0]                 chipid,
    output logic [3*`LOGO_COLOR_W-1:0]  rgb_out,    // to the video connector
    output logic                        hs_out,
    output logic                        vs_out,
    output logic                        lhbl_out,
    output logic                        lvbl_out
);

    logo_pkg::coord_t     hcnt;
    logo_pkg::coord_t     vcnt;
    logo_pkg::coord_t     hover;
    logo_pkg::coord_t     vover;
    logo_pkg::prom_addr_t rd_addr;   // mixer to memory
    logo_pkg::prom_byte_t rom;
    logic                 idpxl;

    screen_measure u_measure (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .hcnt    (hcnt),
        .vcnt    (vcnt),
        .hover   (hover),
        .vover   (vover)
    );

    logo_prom u_prom (
        .clk     (clk),
        .rd_addr (rd_addr),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .we      (prog_we),
        .q       (rom)
    );

    hex_display u_hex (
        .hcnt    (hcnt),
        .vcnt    (vcnt),
        .chipid  (chipid),
        .pxl     (idpxl)
    );

    logo_mixer u_mixer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .show_en  (show_en),
        .hcnt     (hcnt),
        .vcnt     (vcnt),
        .hover    (hover),
        .vover    (vover),
        .rom      (rom),
        .idpxl    (idpxl),
        .rgb_in   (rgb_in),
        .hs       (hs),
        .vs       (vs),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .addr     (rd_addr),
        .rgb_out  (rgb_out),
        .hs_out   (hs_out),
        .vs_out   (vs_out),
        .lhbl_out (lhbl_out),
        .lvbl_out (lvbl_out)
    );

endmodule

/* verilog/logo_prom.sv */
// logo_prom, simple dual-port logo bitmap memory with download write and registered read
`timescale 1ns/1ps
`include "logo_defines.svh"

module logo_prom (
    input  logic                  clk,
    input  logo_pkg::prom_addr_t  rd_addr,  // from the mixer, follows the beam
    input  logo_pkg::prom_addr_t  wr_addr,  // download side
    input  logo_pkg::prom_byte_t  wr_data,
    input  logic                  we,       // one clk strobe per byte
    output logo_pkg::prom_byte_t  q
);

    localparam int unsigned DEPTH = 2 ** `LOGO_PROM_AW;   // 2048 bytes

    logo_pkg::prom_byte_t mem [DEPTH];    // starts undefined, filled by download

    // write port, no pixel enable here
    // download runs at full clk rate
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port registers every clk
    // two clk per pixel so data is ready before the next pxl_cen
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

/* verilog/screen_measure.sv */
// screen_measure, active pixel and line counters, picture size and logo centring offsets
`timescale 1ns/1ps
`include "logo_defines.svh"

module screen_measure (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    input  logic             lhbl,      // high in active part of a line
    input  logic             lvbl,      // high in active lines
    output logo_pkg::coord_t hcnt,      // active pixels seen so far in this line
    output logo_pkg::coord_t vcnt,      // active lines seen so far in this frame
    output logo_pkg::coord_t hover,     // left margin to centre the logo
    output logo_pkg::coord_t vover      // top margin to centre the logo
);

    logo_pkg::coord_t htot;     // active width, last line
    logo_pkg::coord_t vtot;     // active height, last frame
    logic             lhbl_l;   // blanking one pixel ago
    logic             lvbl_l;
    logic             hbl_fall; // end of active line
    logic             vbl_fall; // end of active frame

    assign hbl_fall = lhbl_l & ~lhbl;
    assign vbl_fall = lvbl_l & ~lvbl;

    // edge detect copies
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_l <= 1'b0;
            lvbl_l <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_l <= lhbl;
            lvbl_l <= lvbl;
        end
    end

    // pixel and line counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
            htot <= '0;
        end else if (pxl_cen) begin
            hcnt <= lhbl ? hcnt + 9'd1 : 9'd0;     // held at 0 in hblank
            if (hbl_fall) begin
                htot <= hcnt;                       // full count of this line
            end
            if (!lvbl) begin
                vcnt <= '0;                         // cleared all through vblank
            end else if (hbl_fall) begin
                vcnt <= vcnt + 9'd1;
            end
        end
    end

    // size and offsets, once per frame
    // hover uses htot from the last line of the frame
    // vover uses vtot of the frame before, so valid from the second frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vtot  <= '0;
            hover <= '0;
            vover <= '0;
        end else if (pxl_cen && vbl_fall) begin
            vtot  <= vcnt;
            hover <= (htot < 9'(`LOGO_W)) ? 9'd0 : (htot - 9'(`LOGO_W)) >> 1;
            vover <= (vtot < 9'(`LOGO_H)) ? 9'd0 : (vtot - 9'(`LOGO_H)) >> 1;
        end
    end

endmodule
